/* src/exec_pkg.sv */
package exec_pkg;

  localparam int xlen = 32;
  localparam int reg_aw = 5;
  localparam int csr_aw = 12;

  localparam int mpp_lo = 11; // mstatus.MPP sits in bits 12:11

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    md_mul, md_mulh, md_mulhsu, md_mulhu,
    md_div, md_divu, md_rem, md_remu
  } muldiv_op_t;

  typedef enum logic [1:0] {csr_none, csr_rw, csr_rs, csr_rc} csr_op_t;

  typedef enum logic [1:0] {
    priv_user = 2'd0,
    priv_mach = 2'd3
  } priv_t;

  typedef enum logic [3:0] {
    cause_illegal    = 4'd2,
    cause_breakpoint = 4'd3,
    cause_ecall_u    = 4'd8,
    cause_ecall_m    = 4'd11
  } cause_t;

  // machine mode CSRs plus the cycle counter
  localparam logic [csr_aw-1:0] csr_mstatus    = 12'h300;
  localparam logic [csr_aw-1:0] csr_mcounteren = 12'h306;
  localparam logic [csr_aw-1:0] csr_mscratch   = 12'h340;
  localparam logic [csr_aw-1:0] csr_mepc       = 12'h341;
  localparam logic [csr_aw-1:0] csr_mcause     = 12'h342;
  localparam logic [csr_aw-1:0] csr_mtval      = 12'h343;
  localparam logic [csr_aw-1:0] csr_mcycle     = 12'hb00;

endpackage

/* src/exec_ifc.sv */
`timescale 1ns/10ps

interface issue_ifc;
  import exec_pkg::*;

  logic valid;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] imm;
  logic [reg_aw-1:0] rd;
  alu_op_t alu_op;
  logic use_imm;
  muldiv_op_t muldiv_op;
  logic muldiv;
  csr_op_t csr_op;
  logic [csr_aw-1:0] csr_addr;
  logic [reg_aw-1:0] csr_uimm;
  logic lui;
  logic auipc;
  logic jal;
  logic ecall;
  logic ebreak;
  logic mret;
  logic illegal;

  modport src (output valid, pc, instr, rdata1, rdata2, imm, rd, alu_op, use_imm, muldiv_op,
               muldiv, csr_op, csr_addr, csr_uimm, lui, auipc, jal, ecall, ebreak, mret, illegal);
  modport dst (input valid, pc, instr, rdata1, rdata2, imm, rd, alu_op, use_imm, muldiv_op,
               muldiv, csr_op, csr_addr, csr_uimm, lui, auipc, jal, ecall, ebreak, mret, illegal);
endinterface

interface wb_ifc;
  import exec_pkg::*;

  logic wren;
  logic [reg_aw-1:0] waddr;
  logic [xlen-1:0] wdata;

  modport src (output wren, waddr, wdata);
  modport dst (input wren, waddr, wdata);
endinterface

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
  input logic [exec_pkg::xlen-1:0] a,
  input logic [exec_pkg::xlen-1:0] b,
  input exec_pkg::alu_op_t op,
  output logic [exec_pkg::xlen-1:0] res
);
  import exec_pkg::*;

  logic [4:0] shamt;
  logic lt_s;
  logic lt_u;

  assign shamt = b[4:0];
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        res = a + b;
      end
      alu_sub: begin
        res = a - b;
      end
      alu_sll: begin
        res = a << shamt;
      end
      alu_slt: begin
        res = {{(xlen-1){1'b0}}, lt_s};
      end
      alu_sltu: begin
        res = {{(xlen-1){1'b0}}, lt_u};
      end
      alu_xor: begin
        res = a ^ b;
      end
      alu_srl: begin
        res = a >> shamt;
      end
      alu_sra: begin
        res = $signed(a) >>> shamt; // sign fill
      end
      alu_or: begin
        res = a | b;
      end
      alu_and: begin
        res = a & b;
      end
      default: begin
        res = '0;
      end
    endcase
  end

endmodule

/* src/mul_div.sv */
`timescale 1ns/10ps

module mul_div (
  input logic clk,
  input logic rst,
  input logic start,
  input exec_pkg::muldiv_op_t op,
  input logic [exec_pkg::xlen-1:0] a,
  input logic [exec_pkg::xlen-1:0] b,
  output logic ready,
  output logic [exec_pkg::xlen-1:0] result
);
  import exec_pkg::*;

  typedef enum logic [1:0] {st_idle, st_busy, st_done} state_t;

  state_t state;
  logic [4:0] cnt;
  muldiv_op_t op_q;
  logic [2*xlen-1:0] acc;  // product, or remainder:quotient
  logic [xlen-1:0] opnd;   // multiplicand or divisor magnitude
  logic neg_res;
  logic neg_rem;
  logic b_zero;
  logic is_div_q;
  logic a_neg;
  logic b_neg;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic [xlen:0] mul_sum;
  logic [xlen+1:0] div_diff;
  logic [2*xlen-1:0] prod;
  logic [xlen-1:0] quot;
  logic [xlen-1:0] rem;

  assign a_neg = a[xlen-1] && (op inside {md_mulh, md_mulhsu, md_div, md_rem});
  assign b_neg = b[xlen-1] && (op inside {md_mulh, md_div, md_rem});
  assign mag_a = a_neg ? -a : a;
  assign mag_b = b_neg ? -b : b;
  assign is_div_q = op_q inside {md_div, md_divu, md_rem, md_remu};

  assign mul_sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, opnd} : '0);
  assign div_diff = {1'b0, acc[2*xlen-1:xlen-1]} - {2'b00, opnd}; // shifted remainder minus divisor

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
      cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_busy;
            cnt <= '0;
          end
        end
        st_busy: begin
          cnt <= cnt + 1'b1;
          if (cnt == 5'd31) begin
            state <= st_done;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      op_q <= op;
      acc <= {{xlen{1'b0}}, mag_a};
      opnd <= mag_b;
      neg_res <= a_neg ^ b_neg;
      neg_rem <= a_neg;
      b_zero <= b == '0;
    end else if (state == st_busy) begin
      if (is_div_q) begin
        acc <= {div_diff[xlen+1] ? acc[2*xlen-2:xlen-1] : div_diff[xlen-1:0],
                acc[xlen-2:0], ~div_diff[xlen+1]};
      end else begin
        acc <= {mul_sum, acc[xlen-1:1]};
      end
    end
  end

  assign prod = neg_res ? -acc : acc;
  assign quot = b_zero ? '1 : (neg_res ? -acc[xlen-1:0] : acc[xlen-1:0]);
  assign rem = neg_rem ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];
  assign ready = state == st_done;

  always_comb begin
    case (op_q)
      md_mul: result = prod[xlen-1:0];
      md_mulh, md_mulhsu, md_mulhu: result = prod[2*xlen-1:xlen];
      md_div, md_divu: result = quot;
      default: result = rem;
    endcase
  end

endmodule

/* src/csr_unit.sv */
`timescale 1ns/10ps

module csr_unit (
  input logic clk,
  input logic rst,
  input logic [exec_pkg::csr_aw-1:0] raddr,
  input logic wen,
  input logic [exec_pkg::csr_aw-1:0] waddr,
  input logic [exec_pkg::xlen-1:0] wdata,
  input logic trap,
  input exec_pkg::cause_t trap_cause,
  input logic [exec_pkg::xlen-1:0] trap_pc,
  input logic [exec_pkg::xlen-1:0] trap_tval,
  input logic mret,
  output logic [exec_pkg::xlen-1:0] rdata,
  output exec_pkg::priv_t mode,
  output logic [exec_pkg::xlen-1:0] mcounteren
);
  import exec_pkg::*;

  priv_t mpp;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] mcycle;
  logic wr_ok;

  assign wr_ok = wen && waddr[11:10] != 2'b11; // 11 in the top bits marks read-only

  always_ff @(posedge clk) begin
    if (!rst) begin
      mode <= priv_mach;
      mpp <= priv_user;
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
      mcounteren <= '0;
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;
      if (trap) begin
        mepc <= trap_pc;
        mcause <= {{(xlen-4){1'b0}}, trap_cause};
        mtval <= trap_tval;
        mpp <= mode;
        mode <= priv_mach;
      end else if (mret) begin
        mode <= mpp;
        mpp <= priv_user;
      end else if (wr_ok) begin
        case (waddr)
          csr_mstatus: mpp <= (wdata[mpp_lo +: 2] == 2'b11) ? priv_mach : priv_user;
          csr_mscratch: mscratch <= wdata;
          csr_mepc: mepc <= wdata;
          csr_mcause: mcause <= wdata;
          csr_mtval: mtval <= wdata;
          csr_mcounteren: mcounteren <= wdata;
          csr_mcycle: mcycle <= wdata; // write wins over the increment
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (raddr)
      csr_mstatus: rdata = {{(xlen-mpp_lo-2){1'b0}}, mpp, {mpp_lo{1'b0}}};
      csr_mscratch: rdata = mscratch;
      csr_mepc: rdata = mepc;
      csr_mcause: rdata = mcause;
      csr_mtval: rdata = mtval;
      csr_mcounteren: rdata = mcounteren;
      csr_mcycle: rdata = mcycle;
      default: rdata = '0;
    endcase
  end

endmodule

/* src/operand_stage.sv */
`timescale 1ns/10ps

module operand_stage (
  input logic clk,
  input logic rst,
  input logic issue,
  input logic [exec_pkg::xlen-1:0] pc,
  input logic [exec_pkg::xlen-1:0] instr,
  input logic [exec_pkg::reg_aw-1:0] rs1,
  input logic [exec_pkg::reg_aw-1:0] rs2,
  input logic [exec_pkg::reg_aw-1:0] rd,
  input logic [exec_pkg::xlen-1:0] imm,
  input exec_pkg::alu_op_t alu_op,
  input logic use_imm,
  input logic muldiv,
  input exec_pkg::muldiv_op_t muldiv_op,
  input exec_pkg::csr_op_t csr_op,
  input logic [exec_pkg::csr_aw-1:0] csr_addr,
  input logic [exec_pkg::reg_aw-1:0] csr_uimm,
  input logic lui,
  input logic auipc,
  input logic jal,
  input logic ecall,
  input logic ebreak,
  input logic mret,
  input logic illegal,
  input logic stall,
  issue_ifc.src iss,
  wb_ifc.dst wb
);
  import exec_pkg::*;

  logic [xlen-1:0] regs [1:31]; // x0 is not stored

  // register read with bypass from the execute result
  function automatic logic [xlen-1:0] read_reg(input logic [reg_aw-1:0] addr);
    logic [xlen-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (wb.wren && wb.waddr == addr) begin
      val = wb.wdata;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (wb.wren && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      iss.valid <= 1'b0;
    end else if (!stall) begin
      iss.valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin // hold the instruction while execute waits
      iss.pc <= pc;
      iss.instr <= instr;
      iss.rdata1 <= read_reg(rs1);
      iss.rdata2 <= read_reg(rs2);
      iss.imm <= imm;
      iss.rd <= rd;
      iss.alu_op <= alu_op;
      iss.use_imm <= use_imm;
      iss.muldiv_op <= muldiv_op;
      iss.muldiv <= muldiv;
      iss.csr_op <= csr_op;
      iss.csr_addr <= csr_addr;
      iss.csr_uimm <= csr_uimm;
      iss.lui <= lui;
      iss.auipc <= auipc;
      iss.jal <= jal;
      iss.ecall <= ecall;
      iss.ebreak <= ebreak;
      iss.mret <= mret;
      iss.illegal <= illegal;
    end
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
  input logic clk,
  input logic rst,
  issue_ifc.dst iss,
  wb_ifc.src wb,
  output logic [exec_pkg::xlen-1:0] alu_a,
  output logic [exec_pkg::xlen-1:0] alu_b,
  output exec_pkg::alu_op_t alu_op,
  input logic [exec_pkg::xlen-1:0] alu_res,
  output logic md_start,
  output exec_pkg::muldiv_op_t md_op,
  output logic [exec_pkg::xlen-1:0] md_a,
  output logic [exec_pkg::xlen-1:0] md_b,
  input logic md_ready,
  input logic [exec_pkg::xlen-1:0] md_result,
  output logic [exec_pkg::csr_aw-1:0] csr_raddr,
  output logic csr_wen,
  output logic [exec_pkg::csr_aw-1:0] csr_waddr,
  output logic [exec_pkg::xlen-1:0] csr_wdata,
  output logic csr_trap,
  output exec_pkg::cause_t csr_cause,
  output logic [exec_pkg::xlen-1:0] csr_pc,
  output logic [exec_pkg::xlen-1:0] csr_tval,
  output logic csr_mret,
  input logic [exec_pkg::xlen-1:0] csr_rdata,
  input exec_pkg::priv_t csr_mode,
  input logic [exec_pkg::xlen-1:0] csr_mcounteren,
  output logic stall,
  output logic retire_valid,
  output logic [exec_pkg::reg_aw-1:0] retire_waddr,
  output logic [exec_pkg::xlen-1:0] retire_wdata,
  output logic trap,
  output exec_pkg::cause_t trap_cause,
  output logic [exec_pkg::xlen-1:0] trap_pc,
  output logic [exec_pkg::xlen-1:0] trap_tval
);
  import exec_pkg::*;

  logic csr_acc;
  logic csr_denied;
  logic illegal;
  logic exc;
  logic md_wait;
  logic md_busy;
  logic [xlen-1:0] csr_src;
  logic [xlen-1:0] result;
  cause_t cause;
  logic [xlen-1:0] tval;

  assign csr_acc = iss.csr_op != csr_none;
  // counters below machine level are opened per bit by mcounteren
  assign csr_denied = csr_acc && (csr_mode < iss.csr_addr[9:8]) &&
      !(iss.csr_addr[11:8] == 4'hb && csr_mcounteren[iss.csr_addr[4:0]]);
  assign illegal = iss.illegal || csr_denied || (iss.mret && csr_mode != priv_mach);
  assign exc = iss.valid && (illegal || iss.ebreak || iss.ecall);

  always_comb begin
    if (illegal) begin
      cause = cause_illegal;
      tval = iss.instr;
    end else if (iss.ebreak) begin
      cause = cause_breakpoint;
      tval = iss.instr;
    end else begin
      cause = (csr_mode == priv_mach) ? cause_ecall_m : cause_ecall_u;
      tval = '0;
    end
  end

  assign alu_a = iss.rdata1;
  assign alu_b = iss.use_imm ? iss.imm : iss.rdata2;
  assign alu_op = iss.alu_op;

  // one start per muldiv, then wait for the ready pulse
  assign md_wait = iss.valid && iss.muldiv && !exc;
  assign md_start = md_wait && !md_busy;
  assign stall = md_wait && !md_ready;
  assign md_op = iss.muldiv_op;
  assign md_a = iss.rdata1;
  assign md_b = iss.rdata2;

  always_ff @(posedge clk) begin
    if (!rst) begin
      md_busy <= 1'b0;
    end else if (md_start) begin
      md_busy <= 1'b1;
    end else if (md_ready) begin
      md_busy <= 1'b0;
    end
  end

  assign csr_src = iss.use_imm ? {{(xlen-reg_aw){1'b0}}, iss.csr_uimm} : iss.rdata1;
  assign csr_raddr = iss.csr_addr;
  assign csr_waddr = iss.csr_addr;
  assign csr_wen = iss.valid && csr_acc && !exc && (iss.csr_op == csr_rw || csr_src != '0);

  always_comb begin
    case (iss.csr_op)
      csr_rw: csr_wdata = csr_src;
      csr_rs: csr_wdata = csr_rdata | csr_src;
      csr_rc: csr_wdata = csr_rdata & ~csr_src;
      default: csr_wdata = csr_rdata;
    endcase
  end

  assign csr_trap = exc;
  assign csr_cause = cause;
  assign csr_pc = iss.pc;
  assign csr_tval = tval;
  assign csr_mret = iss.valid && iss.mret && !exc;

  always_comb begin
    if (iss.auipc) begin
      result = iss.pc + iss.imm;
    end else if (iss.lui) begin
      result = iss.imm;
    end else if (iss.jal) begin
      result = iss.pc + 32'd4; // link
    end else if (csr_acc) begin
      result = csr_rdata;
    end else if (iss.muldiv) begin
      result = md_result;
    end else begin
      result = alu_res;
    end
  end

  // mret completes without a register write, so it never shows on retire
  assign wb.wren = iss.valid && !exc && !iss.mret && !stall && iss.rd != '0;
  assign wb.waddr = iss.rd;
  assign wb.wdata = result;

  always_ff @(posedge clk) begin
    if (!rst) begin
      retire_valid <= 1'b0;
      trap <= 1'b0;
    end else begin
      retire_valid <= wb.wren;
      trap <= exc;
    end
  end

  always_ff @(posedge clk) begin
    retire_waddr <= wb.waddr;
    retire_wdata <= wb.wdata;
    trap_cause <= cause;
    trap_pc <= iss.pc;
    trap_tval <= tval;
  end

endmodule

/* src/exec_core.sv */
`timescale 1ns/10ps

module exec_core (
  input logic clk,
  input logic rst,
  input logic issue,
  input logic [exec_pkg::xlen-1:0] pc,
  input logic [exec_pkg::xlen-1:0] instr,
  input logic [exec_pkg::reg_aw-1:0] rs1,
  input logic [exec_pkg::reg_aw-1:0] rs2,
  input logic [exec_pkg::reg_aw-1:0] rd,
  input logic [exec_pkg::xlen-1:0] imm,
  input exec_pkg::alu_op_t alu_op,
  input logic use_imm,
  input logic muldiv,
  input exec_pkg::muldiv_op_t muldiv_op,
  input exec_pkg::csr_op_t csr_op,
  input logic [exec_pkg::csr_aw-1:0] csr_addr,
  input logic [exec_pkg::reg_aw-1:0] csr_uimm,
  input logic lui,
  input logic auipc,
  input logic jal,
  input logic ecall,
  input logic ebreak,
  input logic mret,
  input logic illegal,
  output logic stall,
  output logic retire_valid,
  output logic [exec_pkg::reg_aw-1:0] retire_waddr,
  output logic [exec_pkg::xlen-1:0] retire_wdata,
  output logic trap,
  output exec_pkg::cause_t trap_cause,
  output logic [exec_pkg::xlen-1:0] trap_pc,
  output logic [exec_pkg::xlen-1:0] trap_tval
);
  import exec_pkg::*;

  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  alu_op_t ex_alu_op;
  logic [xlen-1:0] alu_res;
  logic md_start;
  muldiv_op_t md_op;
  logic [xlen-1:0] md_a;
  logic [xlen-1:0] md_b;
  logic md_ready;
  logic [xlen-1:0] md_result;
  logic [csr_aw-1:0] csr_raddr;
  logic csr_wen;
  logic [csr_aw-1:0] csr_waddr;
  logic [xlen-1:0] csr_wdata;
  logic csr_trap;
  cause_t csr_cause;
  logic [xlen-1:0] csr_pc;
  logic [xlen-1:0] csr_tval;
  logic csr_mret;
  logic [xlen-1:0] csr_rdata;
  priv_t csr_mode;
  logic [xlen-1:0] csr_mcounteren;

  issue_ifc iss ();
  wb_ifc wb ();

  operand_stage u_operand_stage (
    .clk, .rst, .issue, .pc, .instr, .rs1, .rs2, .rd, .imm, .alu_op, .use_imm,
    .muldiv, .muldiv_op, .csr_op, .csr_addr, .csr_uimm, .lui, .auipc, .jal,
    .ecall, .ebreak, .mret, .illegal, .stall,
    .iss(iss.src),
    .wb(wb.dst)
  );

  execute_stage u_execute_stage (
    .clk, .rst,
    .iss(iss.dst),
    .wb(wb.src),
    .alu_a, .alu_b, .alu_op(ex_alu_op), .alu_res,
    .md_start, .md_op, .md_a, .md_b, .md_ready, .md_result,
    .csr_raddr, .csr_wen, .csr_waddr, .csr_wdata, .csr_trap, .csr_cause,
    .csr_pc, .csr_tval, .csr_mret, .csr_rdata, .csr_mode, .csr_mcounteren,
    .stall, .retire_valid, .retire_waddr, .retire_wdata,
    .trap, .trap_cause, .trap_pc, .trap_tval
  );

  alu u_alu (
    .a(alu_a),
    .b(alu_b),
    .op(ex_alu_op),
    .res(alu_res)
  );

  mul_div u_mul_div (
    .clk, .rst,
    .start(md_start),
    .op(md_op),
    .a(md_a),
    .b(md_b),
    .ready(md_ready),
    .result(md_result)
  );

  csr_unit u_csr_unit (
    .clk, .rst,
    .raddr(csr_raddr),
    .wen(csr_wen),
    .waddr(csr_waddr),
    .wdata(csr_wdata),
    .trap(csr_trap),
    .trap_cause(csr_cause),
    .trap_pc(csr_pc),
    .trap_tval(csr_tval),
    .mret(csr_mret),
    .rdata(csr_rdata),
    .mode(csr_mode),
    .mcounteren(csr_mcounteren)
  );

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
  output logic clk,
  output logic rst
);
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
  end
endmodule

/* testbench/exec_core_assertions.sv */
`timescale 1ns/10ps

module exec_core_assertions (
  input logic clk,
  input logic rst,
  input logic stall,
  input logic retire_valid,
  input logic trap,
  input logic [exec_pkg::reg_aw-1:0] retire_waddr
);
  logic [7:0] stall_cycles;
  int fails = 0; // read by the testbench for its closing count

  // length of the current stall run
  always_ff @(posedge clk) begin
    if (!rst) begin
      stall_cycles <= '0;
    end else if (stall && stall_cycles != 8'hff) begin
      stall_cycles <= stall_cycles + 1'b1;
    end else if (!stall) begin
      stall_cycles <= '0;
    end
  end

  retire_trap_excl: assert property (@(posedge clk) disable iff (!rst)
      !(retire_valid && trap))
    else begin
      $error("retire_valid and trap high in the same cycle");
      fails++;
    end

  retire_no_x0: assert property (@(posedge clk) disable iff (!rst)
      retire_valid |-> retire_waddr != '0)
    else begin
      $error("retire reported a write to x0");
      fails++;
    end

  stall_bounded: assert property (@(posedge clk) disable iff (!rst)
      stall_cycles <= 8'd40)
    else begin
      $error("stall held high for more than 40 cycles");
      fails++;
    end

  reset_quiet: assert property (@(posedge clk)
      $rose(rst) |-> !retire_valid && !trap && !stall)
    else begin
      $error("outputs not idle in the first cycle after reset");
      fails++;
    end
endmodule

/* testbench/exec_core_tb.sv */
`timescale 1ns/10ps

module exec_core_tb;
  import exec_pkg::*;

  localparam int tmo = 100;

  logic clk;
  logic rst;
  logic issue;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] instr;
  logic [reg_aw-1:0] rs1;
  logic [reg_aw-1:0] rs2;
  logic [reg_aw-1:0] rd;
  logic [xlen-1:0] imm;
  alu_op_t alu_op;
  logic use_imm;
  logic muldiv;
  muldiv_op_t muldiv_op;
  csr_op_t csr_op;
  logic [csr_aw-1:0] csr_addr;
  logic [reg_aw-1:0] csr_uimm;
  logic lui;
  logic auipc;
  logic jal;
  logic ecall;
  logic ebreak;
  logic mret;
  logic illegal;
  logic stall;
  logic retire_valid;
  logic [reg_aw-1:0] retire_waddr;
  logic [xlen-1:0] retire_wdata;
  logic trap;
  cause_t trap_cause;
  logic [xlen-1:0] trap_pc;
  logic [xlen-1:0] trap_tval;

  int errors = 0;
  int last_cycles;
  int last_stall_low;
  logic [31:0] lfsr = 32'hdba6_f170;
  logic [31:0] ref_regs [0:31];
  logic [31:0] ipc;
  logic [31:0] iinstr;
  logic [31:0] next_pc = 32'h0000_1000;
  logic [31:0] m_mscratch = '0;
  logic [31:0] m_mepc = '0;
  logic [31:0] m_mcause = '0;
  logic [31:0] m_mtval = '0;
  priv_t m_mode = priv_mach;
  priv_t m_mpp = priv_user;

  clock_gen u_clock_gen (.clk(clk), .rst(rst));

  exec_core u_exec_core (.*);

  bind exec_core exec_core_assertions u_exec_core_assertions (
    .clk(clk), .rst(rst), .stall(stall), .retire_valid(retire_valid),
    .trap(trap), .retire_waddr(retire_waddr)
  );

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_sll: return a << b[4:0];
      alu_slt: return {31'd0, $signed(a) < $signed(b)};
      alu_sltu: return {31'd0, a < b};
      alu_xor: return a ^ b;
      alu_srl: return a >> b[4:0];
      alu_sra: return $unsigned($signed(a) >>> b[4:0]);
      alu_or: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] md_ref(input muldiv_op_t op, input logic [31:0] a,
                                         input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] za;
    logic [63:0] zb;
    logic [63:0] p;
    logic ovf;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    za = {32'd0, a};
    zb = {32'd0, b};
    ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
    case (op)
      md_mul: p = za * zb;
      md_mulh: p = sa * sb;
      md_mulhsu: p = sa * zb;
      default: p = za * zb;
    endcase
    case (op)
      md_mul: return p[31:0];
      md_mulh, md_mulhsu, md_mulhu: return p[63:32];
      md_div: return (b == 0) ? 32'hffff_ffff : ovf ? a : $unsigned($signed(a) / $signed(b));
      md_divu: return (b == 0) ? 32'hffff_ffff : a / b;
      md_rem: return (b == 0) ? a : ovf ? 32'd0 : $unsigned($signed(a) % $signed(b));
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else begin
      errors++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic set_defaults();
    issue <= 1'b0;
    pc <= '0;
    instr <= '0;
    rs1 <= '0;
    rs2 <= '0;
    rd <= '0;
    imm <= '0;
    alu_op <= alu_add;
    use_imm <= 1'b0;
    muldiv <= 1'b0;
    muldiv_op <= md_mul;
    csr_op <= csr_none;
    csr_addr <= '0;
    csr_uimm <= '0;
    lui <= 1'b0;
    auipc <= 1'b0;
    jal <= 1'b0;
    ecall <= 1'b0;
    ebreak <= 1'b0;
    mret <= 1'b0;
    illegal <= 1'b0;
  endtask

  // called at a rising edge; the caller then overrides fields
  task automatic issue_begin();
    set_defaults();
    ipc = next_pc;
    next_pc = next_pc + 4;
    iinstr = rand_bits(32);
    pc <= ipc;
    instr <= iinstr;
    issue <= 1'b1;
  endtask

  // hold the issue until an edge without stall takes it
  task automatic issue_end();
    int i;
    for (i = 0; i < tmo; i++) begin
      @(negedge clk);
      if (!stall) break;
    end
    if (i == tmo) begin
      errors++;
      $display("timeout: stall never released while an issue was held");
    end
    @(posedge clk);
    issue <= 1'b0;
  endtask

  task automatic alu_issue(input alu_op_t op, input logic [4:0] d, input logic [4:0] s1,
                           input logic [4:0] s2, input logic ui, input logic [31:0] im);
    issue_begin();
    alu_op <= op;
    rd <= d;
    rs1 <= s1;
    rs2 <= s2;
    use_imm <= ui;
    imm <= im;
    issue_end();
  endtask

  task automatic md_issue(input muldiv_op_t op, input logic [4:0] d, input logic [4:0] s1,
                          input logic [4:0] s2);
    issue_begin();
    muldiv <= 1'b1;
    muldiv_op <= op;
    rd <= d;
    rs1 <= s1;
    rs2 <= s2;
    issue_end();
  endtask

  task automatic csr_issue(input csr_op_t op, input logic [11:0] a, input logic [4:0] d,
                           input logic [4:0] s1, input logic ui, input logic [4:0] u);
    issue_begin();
    csr_op <= op;
    csr_addr <= a;
    rd <= d;
    rs1 <= s1;
    use_imm <= ui;
    csr_uimm <= u;
    issue_end();
  endtask

  // kind selects 0 lui, 1 auipc, 2 jal, 3 ecall, 4 ebreak, 5 mret, 6 illegal
  task automatic flag_issue(input int kind, input logic [4:0] d, input logic [31:0] im);
    issue_begin();
    rd <= d;
    imm <= im;
    case (kind)
      0: lui <= 1'b1;
      1: auipc <= 1'b1;
      2: jal <= 1'b1;
      3: ecall <= 1'b1;
      4: ebreak <= 1'b1;
      5: mret <= 1'b1;
      default: illegal <= 1'b1;
    endcase
    issue_end();
  endtask

  task automatic wait_event(output logic timed_out);
    int i;
    last_stall_low = 0;
    for (i = 1; i <= tmo; i++) begin
      @(negedge clk);
      if (retire_valid || trap) break;
      if (!stall) last_stall_low++;
    end
    last_cycles = i;
    timed_out = i > tmo;
    if (timed_out) begin
      errors++;
      $display("timeout: no retire or trap within %0d cycles", tmo);
    end
  endtask

  task automatic get_retire(input string name, input logic [4:0] d, output logic [31:0] v);
    logic to;
    wait_event(to);
    v = retire_wdata;
    if (!to) begin
      assert (!trap)
      else begin
        errors++;
        $display("%s trapped when a retire was expected", name);
      end
      check_val({name, " waddr"}, {27'd0, d}, {27'd0, retire_waddr});
    end
    @(posedge clk);
  endtask

  task automatic check_retire(input string name, input logic [4:0] d, input logic [31:0] exp);
    logic [31:0] v;
    get_retire(name, d, v);
    check_val(name, exp, v);
    ref_regs[d] = exp;
  endtask

  task automatic check_trap(input string name, input cause_t c, input logic [31:0] tpc,
                            input logic [31:0] tv);
    logic to;
    wait_event(to);
    if (!to) begin
      assert (trap)
      else begin
        errors++;
        $display("%s retired when a trap was expected", name);
      end
      check_val({name, " cause"}, {28'd0, c}, {28'd0, trap_cause});
      check_val({name, " pc"}, tpc, trap_pc);
      check_val({name, " tval"}, tv, trap_tval);
    end
    m_mepc = tpc;
    m_mcause = {28'd0, c};
    m_mtval = tv;
    m_mpp = m_mode;
    m_mode = priv_mach;
    @(posedge clk);
  endtask

  task automatic load_reg(input logic [4:0] d, input logic [31:0] v);
    alu_issue(alu_add, d, 5'd0, 5'd0, 1'b1, v);
    check_retire("load", d, v);
  endtask

  task automatic do_mret();
    flag_issue(5, 5'd0, '0);
    m_mode = m_mpp;
    m_mpp = priv_user;
  endtask

  initial begin
    #200000;
    $display("simulation time limit reached");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] im;
    logic [31:0] v1;
    logic [31:0] v2;
    int i;
    set_defaults();
    for (i = 0; i < tmo; i++) begin
      @(negedge clk);
      if (rst) break;
    end
    if (i == tmo) begin
      errors++;
      $display("timeout: reset never released");
    end
    @(posedge clk);

    // alu ops in register and immediate forms
    for (int k = 0; k < 10; k++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      im = rand_bits(32);
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      alu_issue(alu_op_t'(k), 5'd3, 5'd1, 5'd2, 1'b0, '0);
      check_retire("alu_rr", 5'd3, alu_ref(alu_op_t'(k), a, b));
      check_val("alu latency", 32'd2, last_cycles);
      alu_issue(alu_op_t'(k), 5'd4, 5'd1, 5'd0, 1'b1, im);
      check_retire("alu_ri", 5'd4, alu_ref(alu_op_t'(k), a, im));
    end
    im = rand_bits(32);
    flag_issue(0, 5'd5, im);
    check_retire("lui", 5'd5, im);
    flag_issue(1, 5'd5, im);
    check_retire("auipc", 5'd5, ipc + im);
    flag_issue(2, 5'd5, im);
    check_retire("jal", 5'd5, ipc + 4);

    // back to back with bypass and a write to x0
    a = rand_bits(32);
    b = rand_bits(32);
    alu_issue(alu_add, 5'd1, 5'd0, 5'd0, 1'b1, a);
    alu_issue(alu_add, 5'd2, 5'd1, 5'd0, 1'b1, b);
    check_retire("fwd_src", 5'd1, a);
    check_retire("fwd_dep", 5'd2, a + b);
    alu_issue(alu_add, 5'd0, 5'd0, 5'd0, 1'b1, a);
    alu_issue(alu_add, 5'd7, 5'd0, 5'd0, 1'b1, b);
    check_retire("x0_read", 5'd7, b);

    // multiply and divide
    a = rand_bits(32);
    b = rand_bits(32);
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    for (int k = 0; k < 8; k++) begin
      md_issue(muldiv_op_t'(k), 5'd3, 5'd1, 5'd2);
      check_retire("muldiv", 5'd3, md_ref(muldiv_op_t'(k), a, b));
      assert (last_stall_low <= 1)
      else begin
        errors++;
        $display("stall dropped before the muldiv result was ready");
      end
    end
    load_reg(5'd2, 32'd0);
    for (int k = 4; k < 8; k++) begin
      md_issue(muldiv_op_t'(k), 5'd3, 5'd1, 5'd2);
      check_retire("div_zero", 5'd3, md_ref(muldiv_op_t'(k), a, 32'd0));
    end
    load_reg(5'd1, 32'h8000_0000);
    load_reg(5'd2, 32'hffff_ffff);
    md_issue(md_div, 5'd3, 5'd1, 5'd2);
    check_retire("div_ovf", 5'd3, 32'h8000_0000);
    md_issue(md_rem, 5'd3, 5'd1, 5'd2);
    check_retire("rem_ovf", 5'd3, 32'd0);
    a = rand_bits(32);
    b = rand_bits(32);
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    md_issue(md_mul, 5'd5, 5'd1, 5'd2);
    alu_issue(alu_add, 5'd6, 5'd5, 5'd0, 1'b1, 32'd1); // held during the stall
    check_retire("held_mul", 5'd5, md_ref(md_mul, a, b));
    check_retire("held_add", 5'd6, ref_regs[5] + 1);

    // csr access on mscratch and mcycle
    im = rand_bits(5);
    csr_issue(csr_rw, csr_mscratch, 5'd3, 5'd1, 1'b0, '0);
    check_retire("csrrw_old", 5'd3, m_mscratch);
    m_mscratch = ref_regs[1];
    csr_issue(csr_rs, csr_mscratch, 5'd4, 5'd2, 1'b0, '0);
    check_retire("csrrs_old", 5'd4, m_mscratch);
    m_mscratch = m_mscratch | ref_regs[2];
    csr_issue(csr_rc, csr_mscratch, 5'd5, 5'd0, 1'b1, im[4:0]);
    check_retire("csrrc_old", 5'd5, m_mscratch);
    m_mscratch = m_mscratch & ~im;
    csr_issue(csr_rs, csr_mscratch, 5'd6, 5'd0, 1'b0, '0);
    check_retire("mscratch_new", 5'd6, m_mscratch);
    csr_issue(csr_rs, csr_mcycle, 5'd9, 5'd0, 1'b0, '0);
    get_retire("mcycle_1", 5'd9, v1);
    csr_issue(csr_rs, csr_mcycle, 5'd9, 5'd0, 1'b0, '0);
    get_retire("mcycle_2", 5'd9, v2);
    assert (v2 > v1)
    else begin
      errors++;
      $display("Fail mcycle expected above %h actual %h", v1, v2);
    end

    // traps in machine mode
    flag_issue(6, 5'd3, '0);
    check_trap("illegal", cause_illegal, ipc, iinstr);
    flag_issue(4, 5'd3, '0);
    check_trap("ebreak", cause_breakpoint, ipc, iinstr);
    csr_issue(csr_rs, csr_mtval, 5'd8, 5'd0, 1'b0, '0);
    check_retire("mtval", 5'd8, m_mtval);
    flag_issue(3, 5'd3, '0);
    check_trap("ecall_m", cause_ecall_m, ipc, 32'd0);
    csr_issue(csr_rs, csr_mepc, 5'd8, 5'd0, 1'b0, '0);
    check_retire("mepc", 5'd8, m_mepc);
    csr_issue(csr_rs, csr_mcause, 5'd8, 5'd0, 1'b0, '0);
    check_retire("mcause", 5'd8, m_mcause);

    // drop to user mode
    csr_issue(csr_rw, csr_mstatus, 5'd10, 5'd0, 1'b0, '0);
    check_retire("mstatus_old", 5'd10, {19'd0, m_mpp, 11'd0});
    m_mpp = priv_user;
    do_mret();
    csr_issue(csr_rs, csr_mscratch, 5'd11, 5'd0, 1'b0, '0);
    check_trap("user_mscratch", cause_illegal, ipc, iinstr);
    do_mret();
    flag_issue(3, 5'd3, '0);
    check_trap("ecall_u", cause_ecall_u, ipc, 32'd0);
    csr_issue(csr_rs, csr_mcounteren, 5'd12, 5'd0, 1'b1, 5'd1);
    check_retire("mcounteren_old", 5'd12, 32'd0);
    do_mret();
    csr_issue(csr_rs, csr_mcycle, 5'd13, 5'd0, 1'b0, '0);
    get_retire("user_mcycle", 5'd13, v1);
    assert (v1 > v2)
    else begin
      errors++;
      $display("Fail user_mcycle expected above %h actual %h", v2, v1);
    end

    repeat (4) @(posedge clk);
    $display("run complete with %0d check errors and %0d assertion failures", errors,
             u_exec_core.u_exec_core_assertions.fails);
    if (errors == 0 && u_exec_core.u_exec_core_assertions.fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end
endmodule

/* exec_core.f */
src/exec_pkg.sv
src/exec_ifc.sv
src/alu.sv
src/mul_div.sv
src/csr_unit.sv
src/operand_stage.sv
src/execute_stage.sv
src/exec_core.sv
testbench/clock_gen.sv
testbench/exec_core_assertions.sv
testbench/exec_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = exec_core_tb
FILELIST  = exec_core.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
